// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -f project.f --top-module power_meter_tb -Mdir obj_dir
	./obj_dir/Vpower_meter_tb +verilator+error+limit+100 | tee sim.log
	@if grep -q "Simulation failed" sim.log || ! grep -q "Simulation passed" sim.log; then \
		echo "test failed"; \
		exit 1; \
	else \
		echo "test passed"; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: logic/dsp_pkg.sv
package dsp_pkg;

  // --------------------------------------------------
  // stream sizes
  // --------------------------------------------------
  localparam int SAMPLE_WIDTH = 16;
  localparam int LANES = 2;
  localparam int FRAC_BITS = 14; // input samples are 2.14.
  localparam int OUT_FRAC_BITS = FRAC_BITS - 2; // squares leave as 4.12.
  localparam int WORD_WIDTH = SAMPLE_WIDTH * LANES;
  localparam int PRODUCT_WIDTH = 2 * SAMPLE_WIDTH;
  localparam int SQ_SHIFT = 2 * FRAC_BITS - OUT_FRAC_BITS; // product bits dropped below the square.

  // --------------------------------------------------
  // accumulator and register sizes
  // --------------------------------------------------
  localparam int SUM_WIDTH = 32;
  localparam int COUNT_WIDTH = 16;
  localparam int WINDOW_LOG2_WIDTH = 4;
  localparam int BEAT_CNT_WIDTH = 2 ** WINDOW_LOG2_WIDTH; // holds 2**15 beats.
  localparam int ADDR_WIDTH = 2;
  localparam int CTRL_ENABLE_BIT = 0;
  localparam int CTRL_WINDOW_LSB = 4;

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

  typedef union packed {
    logic [WORD_WIDTH-1:0] flat;
    sample_t [LANES-1:0] lanes; // lane 0 sits in the low bits.
  } stream_word_t;

  typedef logic [ADDR_WIDTH-1:0] wb_addr_t;
  typedef logic [WORD_WIDTH-1:0] wb_data_t;

  localparam wb_addr_t REG_CTRL = 2'd0;
  localparam wb_addr_t REG_POWER = 2'd1;
  localparam wb_addr_t REG_COUNT = 2'd2;

endpackage

// File: logic/power_accum.sv
`timescale 1ns/1ps
module power_accum (
  input  logic                  clk,
  input  logic                  reset,
  input  dsp_pkg::stream_word_t beat_data,
  input  logic                  beat_valid,
  input  logic                  beat_ready,
  input  logic                  enable,
  input  logic [3:0]            window_log2,
  input  logic                  restart,
  output logic [31:0]           power_sum,
  output logic [15:0]           window_count
);
  import dsp_pkg::*;

  logic [SUM_WIDTH-1:0] run_sum;
  logic [SUM_WIDTH-1:0] beat_power;
  logic [SUM_WIDTH-1:0] sum_next;
  logic [BEAT_CNT_WIDTH-1:0] beat_cnt;
  logic [BEAT_CNT_WIDTH-1:0] cnt_next;
  logic [BEAT_CNT_WIDTH-1:0] window_len;
  logic take;
  logic window_done;

  assign take = enable && beat_valid && beat_ready; // only beats that really leave the meter.

  // squares are never negative, so each lane is widened without sign.
  always_comb begin
    beat_power = '0;
    for (int i = 0; i < LANES; i++) begin
      beat_power = beat_power + SUM_WIDTH'(unsigned'(beat_data.lanes[i]));
    end
  end

  assign sum_next = run_sum + beat_power;
  assign cnt_next = beat_cnt + 1'b1;
  assign window_len = BEAT_CNT_WIDTH'(1) << window_log2;
  assign window_done = cnt_next >= window_len; // also closes a window shrunk mid-way.

  always_ff @(posedge clk) begin
    if (reset || restart) begin
      run_sum <= '0;
      beat_cnt <= '0;
      power_sum <= '0;
      window_count <= '0;
    end else if (take) begin
      if (window_done) begin
        power_sum <= sum_next;
        window_count <= window_count + 1'b1;
        run_sum <= '0;
        beat_cnt <= '0;
      end else begin
        run_sum <= sum_next;
        beat_cnt <= cnt_next;
      end
    end
  end

endmodule

// File: logic/power_meter_top.sv
`timescale 1ns/1ps
module power_meter_top (
  input  logic                  clk,
  input  logic                  reset,
  input  dsp_pkg::stream_word_t in_data,
  input  logic                  in_valid,
  output logic                  in_ready,
  output dsp_pkg::stream_word_t out_data,
  output logic                  out_valid,
  input  logic                  out_ready,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  dsp_pkg::wb_addr_t     wb_adr,
  input  dsp_pkg::wb_data_t     wb_dat_w,
  output dsp_pkg::wb_data_t     wb_dat_r,
  output logic                  wb_ack
);
  import dsp_pkg::*;

  logic enable;
  logic [WINDOW_LOG2_WIDTH-1:0] window_log2;
  logic restart;
  logic [SUM_WIDTH-1:0] power_sum;
  logic [COUNT_WIDTH-1:0] window_count;

  stream_square u_square (
    .clk, .reset,
    .in_data, .in_valid, .in_ready,
    .out_data, .out_valid, .out_ready
  );

  // the accumulator taps the output stream without holding it.
  power_accum u_accum (
    .clk, .reset,
    .beat_data (out_data),
    .beat_valid (out_valid),
    .beat_ready (out_ready),
    .enable, .window_log2, .restart,
    .power_sum, .window_count
  );

  power_regs u_regs (
    .clk, .reset,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .enable, .window_log2, .restart,
    .power_sum, .window_count
  );

endmodule

// File: logic/power_regs.sv
`timescale 1ns/1ps
module power_regs (
  input  logic              clk,
  input  logic              reset,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  dsp_pkg::wb_addr_t wb_adr,
  input  dsp_pkg::wb_data_t wb_dat_w,
  output dsp_pkg::wb_data_t wb_dat_r,
  output logic              wb_ack,
  output logic              enable,
  output logic [3:0]        window_log2,
  output logic              restart,
  input  logic [31:0]       power_sum,
  input  logic [15:0]       window_count
);
  import dsp_pkg::*;

  logic req;
  logic ctrl_write;
  wb_data_t ctrl_word;
  wb_data_t read_word;

  // a request already acked is not served a second time.
  assign req = wb_cyc && wb_stb && !wb_ack;
  assign ctrl_write = req && wb_we && (wb_adr == REG_CTRL);
  assign restart = ctrl_write; // the accumulator clears on the write edge.

  // --------------------------------------------------
  // control register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      enable <= 1'b0;
      window_log2 <= '0;
    end else if (ctrl_write) begin
      enable <= wb_dat_w[CTRL_ENABLE_BIT];
      window_log2 <= wb_dat_w[CTRL_WINDOW_LSB +: WINDOW_LOG2_WIDTH];
    end
  end

  always_comb begin
    ctrl_word = '0;
    ctrl_word[CTRL_ENABLE_BIT] = enable;
    ctrl_word[CTRL_WINDOW_LSB +: WINDOW_LOG2_WIDTH] = window_log2;
  end

  // --------------------------------------------------
  // read path and ack
  // --------------------------------------------------
  always_comb begin
    case (wb_adr)
      REG_CTRL: read_word = ctrl_word;
      REG_POWER: read_word = power_sum;
      REG_COUNT: read_word = WORD_WIDTH'(window_count);
      default: read_word = '0; // the spare address reads as zero.
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      wb_dat_r <= read_word;
    end
  end

endmodule

// File: logic/stream_square.sv
`timescale 1ns/1ps
module stream_square (
  input  logic                 clk,
  input  logic                 reset,
  input  dsp_pkg::stream_word_t in_data,
  input  logic                 in_valid,
  output logic                 in_ready,
  output dsp_pkg::stream_word_t out_data,
  output logic                 out_valid,
  input  logic                 out_ready
);
  import dsp_pkg::*;

  logic signed [PRODUCT_WIDTH-1:0] prod_q [LANES];
  logic prod_valid;
  logic advance;

  // every stage shifts together, so the pipe only stops when the output beat is held.
  assign advance = !out_valid || out_ready;
  assign in_ready = advance;

  // --------------------------------------------------
  // valid bits
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= 1'b0;
      out_valid <= 1'b0;
    end else if (advance) begin
      prod_valid <= in_valid; // an empty slot enters when the source is idle.
      out_valid <= prod_valid;
    end
  end

  // --------------------------------------------------
  // payload
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (advance) begin
      for (int i = 0; i < LANES; i++) begin
        prod_q[i] <= in_data.lanes[i] * in_data.lanes[i]; // full signed product.
      end
    end
  end

  // keep the 4.12 square and truncate the low product bits.
  always_ff @(posedge clk) begin
    if (advance) begin
      for (int i = 0; i < LANES; i++) begin
        out_data.lanes[i] <= prod_q[i][SQ_SHIFT +: SAMPLE_WIDTH];
      end
    end
  end

endmodule

// File: project.f
logic/dsp_pkg.sv
logic/stream_square.sv
logic/power_accum.sv
logic/power_regs.sv
logic/power_meter_top.sv
tests/tb_clock.sv
tests/power_meter_sva.sv
tests/power_meter_tb.sv

// File: tests/power_meter_sva.sv
`timescale 1ns/1ps
module power_meter_sva (
  input logic                  clk,
  input logic                  reset,
  input dsp_pkg::stream_word_t in_data,
  input logic                  in_valid,
  input logic                  in_ready,
  input dsp_pkg::stream_word_t out_data,
  input logic                  out_valid,
  input logic                  out_ready,
  input logic                  wb_ack
);

  int unsigned fail_count = 0; // read by the testbench at the end of the run.

  // --------------------------------------------------
  // stream hold rules
  // --------------------------------------------------
  out_hold: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_data.flat))
    else begin
      fail_count++;
      $error("output beat changed or vanished while held by the sink");
    end

  in_hold: assert property (@(posedge clk) disable iff (reset)
    in_valid && !in_ready |=> in_valid && $stable(in_data.flat))
    else begin
      fail_count++;
      $error("input beat changed or vanished before it was accepted");
    end

  // --------------------------------------------------
  // bus and reset
  // --------------------------------------------------
  ack_single: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
    else begin
      fail_count++;
      $error("wb_ack stayed high for two cycles");
    end

  reset_idle: assert property (@(posedge clk) reset |=> !out_valid)
    else begin
      fail_count++;
      $error("out_valid was high during reset");
    end

endmodule

// File: tests/power_meter_tb.sv
`timescale 1ns/1ps
module power_meter_tb;
  import dsp_pkg::*;

  localparam int SEED = 32'hb54fa1ea;
  localparam int DRIVE_DELAY = 10;
  localparam int RESET_CYCLES = 4;
  localparam int STREAM_CYCLES = 3000;
  localparam int IDLE_CYCLES = 400;
  localparam int TIMEOUT_CYCLES = STREAM_CYCLES + 2000; // reset, drains and bus phases fit in the rest.
  localparam int ACK_LIMIT = 8;
  localparam int DIRECTED_BEATS = 4;
  localparam int DROP_BITS = 2 * FRAC_BITS - 12; // 2.14 squared is 4.28, kept as 4.12.

  logic clk;
  logic reset;
  stream_word_t in_data;
  logic in_valid;
  logic in_ready;
  stream_word_t out_data;
  logic out_valid;
  logic out_ready;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  wb_addr_t wb_adr;
  wb_data_t wb_dat_w;
  wb_data_t wb_dat_r;
  logic wb_ack;

  // extreme lanes go first: {lane 1, lane 0}.
  logic [31:0] directed [DIRECTED_BEATS] = '{32'h8000_7fff, 32'h7fff_8000,
                                             32'hffff_0000, 32'h8001_0001};
  int dir_idx = 0;
  sample_t exp_q [$];
  int in_beats = 0;
  int out_beats = 0;
  int cycle_count = 0;
  int check_count = 0;
  int value_errors = 0;
  int other_errors = 0;
  logic model_enable = 1'b0;
  int window_len = 1;
  int model_beats = 0;
  int model_count = 0;
  wb_data_t model_sum = '0;
  wb_data_t model_power = '0;

  tb_clock #(.PERIOD_NS(100)) u_clock (.clk(clk));

  power_meter_top uut (.*);

  bind power_meter_top power_meter_sva u_sva (
    .clk(clk), .reset(reset), .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
    .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready), .wb_ack(wb_ack)
  );

  // --------------------------------------------------
  // compare tasks and model
  // --------------------------------------------------
  task automatic check_sample(input string name, input sample_t actual, input sample_t expected);
    check_count++;
    if (actual !== expected) begin
      value_errors++;
      $display("[FAIL] %t %s: got %0d expected %0d", $realtime, name, actual, expected);
    end
  endtask

  task automatic check_word(input string name, input wb_data_t actual, input wb_data_t expected);
    check_count++;
    if (actual !== expected) begin
      value_errors++;
      $display("[FAIL] %t %s: got 0x%08h expected 0x%08h", $realtime, name, actual, expected);
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    check_count++;
    if (actual !== expected) begin
      value_errors++;
      $display("[FAIL] %t %s: got %b expected %b", $realtime, name, actual, expected);
    end
  endtask

  function automatic sample_t square_trunc(input sample_t s);
    logic signed [31:0] wide;
    logic signed [31:0] prod;
    wide = 32'(s);
    prod = wide * wide;
    return sample_t'(prod >>> DROP_BITS);
  endfunction

  function automatic stream_word_t next_word();
    stream_word_t w;
    if (dir_idx < DIRECTED_BEATS) begin
      w.flat = directed[dir_idx];
      dir_idx++;
    end else begin
      w.flat = $urandom;
    end
    return w;
  endfunction

  // called at the falling edge, where every handshake signal is settled.
  task automatic observe_beats();
    sample_t exp0;
    sample_t exp1;
    check_flag("in_ready", in_ready, !(out_valid && !out_ready)); // waits only on a held output.
    if (in_valid && in_ready) begin
      exp_q.push_back(square_trunc(in_data.lanes[0]));
      exp_q.push_back(square_trunc(in_data.lanes[1]));
      in_beats++;
    end
    if (out_valid && out_ready) begin
      out_beats++;
      if (exp_q.size() < LANES) begin
        other_errors++;
        $display("output beat %0d left the meter with no input beat to match it", out_beats);
      end else begin
        exp0 = exp_q.pop_front();
        exp1 = exp_q.pop_front();
        check_sample("out_data.lanes[0]", out_data.lanes[0], exp0);
        check_sample("out_data.lanes[1]", out_data.lanes[1], exp1);
        if (model_enable) begin
          model_sum = model_sum + wb_data_t'(exp0) + wb_data_t'(exp1);
          model_beats++;
          if (model_beats == window_len) begin
            model_power = model_sum;
            model_count++;
            model_sum = '0;
            model_beats = 0;
          end
        end
      end
    end
  endtask

  // --------------------------------------------------
  // stream and bus drivers
  // --------------------------------------------------
  task automatic stream_cycle(input bit source_on);
    logic in_taken;
    @(negedge clk);
    in_taken = in_valid && in_ready;
    observe_beats();
    @(posedge clk);
    #(DRIVE_DELAY);
    if (!in_valid || in_taken) begin
      in_valid = source_on && ((dir_idx < DIRECTED_BEATS) || ($urandom_range(3) != 0));
      in_data = next_word();
    end
    out_ready = !source_on || ($urandom_range(3) != 0);
  endtask

  task automatic run_stream(input int cycles);
    repeat (cycles) stream_cycle(1'b1);
  endtask

  task automatic drain_stream();
    while (in_valid || exp_q.size() != 0) begin
      stream_cycle(1'b0);
    end
  endtask

  task automatic bus_cycle(input wb_addr_t addr, input logic write, input wb_data_t wdata,
                           output wb_data_t rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    #(DRIVE_DELAY);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = write;
    wb_adr = addr;
    wb_dat_w = wdata;
    @(negedge clk);
    while (!wb_ack && waited < ACK_LIMIT) begin
      waited++;
      @(negedge clk);
    end
    if (!wb_ack) begin
      other_errors++;
      $display("no ack for address %0d within %0d cycles", addr, ACK_LIMIT);
    end else if (waited != 1) begin
      other_errors++;
      $display("ack for address %0d came %0d cycles after the request instead of 1",
               addr, waited);
    end
    rdata = wb_dat_r;
    @(posedge clk);
    #(DRIVE_DELAY);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic wb_write(input wb_addr_t addr, input wb_data_t data);
    wb_data_t discard;
    bus_cycle(addr, 1'b1, data, discard);
  endtask

  task automatic read_check(input wb_addr_t addr, input wb_data_t expected, input string name);
    wb_data_t got;
    bus_cycle(addr, 1'b0, '0, got);
    check_word(name, got, expected);
  endtask

  // enable in bit 0, window size in bits 7:4; every write restarts the windows.
  task automatic set_control(input logic en, input logic [3:0] log2);
    wb_write(REG_CTRL, {24'd0, log2, 3'd0, en});
    model_enable = en;
    window_len = 1 << log2;
    model_sum = '0;
    model_power = '0;
    model_beats = 0;
    model_count = 0;
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the stream or the bus stalled", cycle_count);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    int sva_fails;
    $timeformat(-9, 0, " ns", 10);
    void'($urandom(SEED));
    reset = 1'b1;
    in_data = '0;
    in_valid = 1'b0;
    out_ready = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    reset = 1'b0;
    @(negedge clk);
    check_flag("out_valid", out_valid, 1'b0);
    read_check(REG_CTRL, '0, "reg_ctrl");
    read_check(REG_POWER, '0, "reg_power");
    read_check(REG_COUNT, '0, "reg_count");
    read_check(2'd3, '0, "reg_spare");
    set_control(1'b1, 4'd3);
    read_check(REG_CTRL, 32'h31, "reg_ctrl");
    wb_write(REG_POWER, 32'hdead_beef); // read only, so nothing changes.
    read_check(REG_POWER, '0, "reg_power");
    read_check(REG_CTRL, 32'h31, "reg_ctrl");
    run_stream(STREAM_CYCLES);
    drain_stream();
    check_word("output beat count", wb_data_t'(out_beats), wb_data_t'(in_beats));
    read_check(REG_COUNT, wb_data_t'(out_beats / 8), "reg_count");
    read_check(REG_POWER, model_power, "reg_power");
    set_control(1'b0, 4'd3);
    read_check(REG_POWER, '0, "reg_power");
    read_check(REG_COUNT, '0, "reg_count");
    run_stream(IDLE_CYCLES);
    drain_stream();
    check_flag("out_valid", out_valid, 1'b0);
    read_check(REG_COUNT, wb_data_t'(model_count), "reg_count");
    read_check(REG_POWER, model_power, "reg_power");
    repeat (2) @(posedge clk);
    sva_fails = int'(uut.u_sva.fail_count);
    $display("checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
             check_count, value_errors, other_errors, sva_fails);
    if (value_errors + other_errors + sva_fails == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps
module tb_clock #(
  parameter int PERIOD_NS = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk; // rising edges at odd multiples of half a period.
  end

endmodule
